// File: ahb_to_axi_bridge.f
+incdir+verilog
verilog/ahb_side_pkg.sv
verilog/axi_side_pkg.sv
verilog/ahb_req_check.sv
verilog/ahb_slave_fsm.sv
verilog/hold_slot.sv
verilog/axi_master_port.sv
verilog/ahb_to_axi_bridge.sv
sim/axi_mem_slave.sv
sim/tb_ahb_to_axi_bridge.sv

// File: sim/axi_mem_slave.sv
//******************************
// AXI4 slave model with dword memory
// Random ready, read delay and read errors
//******************************
`default_nettype none
`include "ahb_bridge_consts.svh"

module axi_mem_slave import axi_side_pkg::*; (
   input  logic    bus_clk,
   input  logic    arst_n,
   input  logic    awvalid,
   output logic    awready,
   input  axi_aw_t aw,
   input  logic    wvalid,
   output logic    wready,
   input  axi_w_t  w,
   output logic    bvalid,
   input  logic    bready,
   input  logic    arvalid,
   output logic    arready,
   input  axi_aw_t ar,
   output logic    rvalid,
   input  logic    rready,
   output axi_r_t  r
);
   timeunit 1ns;
   timeprecision 100ps;

   localparam int WORDS = `LMEM_SIZE / 8;

   logic [`DATA_W-1:0] mem [0:WORDS-1];
   logic [`ADDR_W-1:0] rd_addr;
   int                 rd_delay;
   bit                 rd_wait;     // AR taken, R not yet sent
   bit                 wr_done;
   bit                 r_done;

   // Every dword starts with a value built from its own address
   function automatic logic [`DATA_W-1:0] fill_word(input logic [`ADDR_W-1:0] addr);
      return {addr[31:3], 3'b101, ~addr[31:3], 3'b010};
   endfunction

   function automatic int word_index(input logic [`ADDR_W-1:0] addr);
      return int'((addr - `LMEM_BASE) >> 3);
   endfunction

   initial begin
      for (int i = 0; i < WORDS; i++) begin
         mem[i] = fill_word(`LMEM_BASE + 32'(i * 8));
      end
      awready = 1'b0;
      wready  = 1'b0;
      arready = 1'b0;
      bvalid  = 1'b0;
      rvalid  = 1'b0;
      r       = '0;
      rd_wait = 1'b0;
      forever begin
         //******************************
         // Handshakes seen at the rising edge
         //******************************
         @(posedge bus_clk);
         wr_done = arst_n && awvalid && awready && wvalid && wready;   // Write needs both
         r_done  = rvalid && rready;
         if (wr_done) begin
            for (int b = 0; b < `STRB_W; b++) begin
               if (w.strb[b]) mem[word_index(aw.addr)][8*b +: 8] = w.data[8*b +: 8];
            end
         end
         if (arst_n && arvalid && arready) begin
            rd_wait  = 1'b1;
            rd_addr  = ar.addr;
            rd_delay = $urandom % 4;                // 0 to 3 extra cycles
         end
         // Outputs change on the falling edge
         @(negedge bus_clk);
         if (!arst_n) begin
            awready = 1'b0;
            wready  = 1'b0;
            arready = 1'b0;
            bvalid  = 1'b0;
            rvalid  = 1'b0;
            rd_wait = 1'b0;
         end else begin
            awready = ($urandom % 4) != 0;
            wready  = ($urandom % 4) != 0;
            arready = ($urandom % 3) != 0;
            bvalid  = wr_done;                      // One-cycle response, bready is high
            if (r_done) begin
               rvalid = 1'b0;
            end else if (rd_wait && !rvalid) begin
               if (rd_delay == 0) begin
                  rvalid  = 1'b1;
                  r.data  = mem[word_index(rd_addr)];
                  r.resp  = (($urandom % 10) == 0) ? 2'b10 : 2'b00;  // About one in ten fails
                  rd_wait = 1'b0;
               end else begin
                  rd_delay--;
               end
            end
         end
      end
   end

endmodule

`default_nettype wire

// File: sim/tb_ahb_to_axi_bridge.sv
//******************************
// Testbench for the AHB to AXI bridge
// Random AHB traffic, shadow memory, AXI monitor
//******************************
`default_nettype none
`include "ahb_bridge_consts.svh"

module tb_ahb_to_axi_bridge import axi_side_pkg::*; ();
   timeunit 1ns;
   timeprecision 100ps;

   localparam int TRANSFERS = 400;
   localparam int TIMEOUT   = 200;                // Cycles per wait loop
   localparam int WORDS     = `LMEM_SIZE / 8;

   logic bus_clk, arst_n, hwrite, hsel, hreadyin, hreadyout, hresp;
   logic [`ADDR_W-1:0] haddr;
   logic [2:0]         hsize;
   logic [1:0]         htrans;
   logic [`DATA_W-1:0] hwdata, hrdata;
   logic    awvalid, awready, wvalid, wready, bvalid, bready;
   logic    arvalid, arready, rvalid, rready;
   axi_aw_t aw, ar;
   axi_w_t  w;
   axi_r_t  r;

   logic [`DATA_W-1:0] shadow [0:WORDS-1];   // Reference memory
   axi_cmd_t wr_exp_q [$];                   // Legal writes not yet seen on AXI
   axi_aw_t  rd_exp_q [$];
   int err_count, timeout_count, legal_wr, legal_rd, fault_count, axi_wr_count, axi_rd_count;

   ahb_to_axi_bridge ahb_to_axi_bridge_inst (.*);
   axi_mem_slave     mem_slave_inst (.*);

   initial begin
      bus_clk = 1'b0;
      forever #4 bus_clk = ~bus_clk;           // 8 ns period
   end

   //******************************
   // Reference rules
   //******************************
   function automatic logic [`DATA_W-1:0] fill_word(input logic [`ADDR_W-1:0] addr);
      return {addr[31:3], 3'b101, ~addr[31:3], 3'b010};
   endfunction

   function automatic int word_index(input logic [`ADDR_W-1:0] addr);
      return int'((addr - `LMEM_BASE) >> 3);
   endfunction

   function automatic logic [`STRB_W-1:0] lane_mask(input logic [2:0] size, input logic [2:0] low);
      logic [15:0] run;
      run = (16'd1 << (16'd1 << size)) - 16'd1;   // 1, 2, 4 or 8 ones
      return 8'(run << low);
   endfunction

   function automatic bit is_fault(input logic wr, input logic [31:0] addr, input logic [2:0] size);
      bit outside;
      bit narrow_wr;
      bit misaligned;
      outside    = (addr < `LMEM_BASE) || (addr >= `LMEM_BASE + `LMEM_SIZE);
      narrow_wr  = wr && (size < 3'd2);            // Writes are word or dword only
      misaligned = (addr & ((32'd1 << size) - 32'd1)) != 0;
      return outside || narrow_wr || misaligned;
   endfunction

   task automatic check_that(input bit ok, input string what);
      assert (ok) else begin
         err_count++;
         $display("ERR %0t: %s", $time, what);
      end
   endtask

   task automatic finish_run();
      $display("Errors %0d, timeouts %0d; AHB wr %0d rd %0d faults %0d; AXI wr %0d rd %0d",
               err_count, timeout_count, legal_wr, legal_rd, fault_count, axi_wr_count,
               axi_rd_count);
      if (err_count == 0 && timeout_count == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   endtask

   task automatic give_up(input string what);
      $display("Timeout at %0t: gave up waiting for %s", $time, what);
      timeout_count++;
      finish_run();
   endtask

   task automatic idle_cycles(input int n);
      for (int i = 0; i < n; i++) begin
         hsel   = 1'b0;                            // Unselected, htrans must be ignored
         htrans = ($urandom % 2) ? `HTRANS_NONSEQ : `HTRANS_IDLE;
         haddr  = $urandom;
         @(negedge bus_clk);
      end
   endtask

   //******************************
   // One AHB transfer, address then data phase
   //******************************
   task automatic run_transfer(input logic wr, input logic [31:0] addr, input logic [2:0] size,
                               input logic [`DATA_W-1:0] data);
      bit               fault;
      bit               quiet;                     // No older write left in the slot
      bit               first_hresp;
      bit               r_err;
      bit               done;
      int               waited;
      int               since_r;
      logic [`STRB_W-1:0] strb;
      fault   = is_fault(wr, addr, size);
      strb    = lane_mask(size, addr[2:0]);
      quiet   = (wr_exp_q.size() == 0);
      r_err   = 1'b0;
      since_r = -1;
      hsel    = 1'b1;
      haddr   = addr;
      hsize   = size;
      hwrite  = wr;
      htrans  = `HTRANS_NONSEQ;
      waited  = 0;
      do begin
         @(posedge bus_clk);
         waited++;
         if (waited > TIMEOUT) give_up("address phase acceptance");
      end while (!hreadyout);
      // Model update once the address phase is taken
      if (fault) begin
         fault_count++;
      end else if (wr) begin
         for (int b = 0; b < `STRB_W; b++) begin
            if (strb[b]) shadow[word_index(addr)][8*b +: 8] = data[8*b +: 8];
         end
         wr_exp_q.push_back('{write: 1'b1, addr: addr, size: size[1:0], strb: strb, wdata: data});
         legal_wr++;
      end else begin
         rd_exp_q.push_back('{addr: addr, size: size});
         legal_rd++;
      end
      @(negedge bus_clk);
      htrans = `HTRANS_IDLE;
      hwdata = data;                               // Held through any stall
      waited = 0;
      done   = 1'b0;
      while (!done) begin
         @(posedge bus_clk);
         waited++;
         if (since_r >= 0) since_r++;
         if (rvalid && rready) begin
            since_r = 0;
            r_err   = (r.resp != 2'b00);
         end
         if (waited == 1) first_hresp = hresp;
         if (fault) check_that(!arvalid && (!quiet || !awvalid), "AXI valid on an error response");
         if (wr && !fault && !hreadyout) check_that(awvalid, "write stall with empty slot");
         done = hreadyout;
         if (waited > TIMEOUT) give_up("data phase completion");
      end
      if (fault) begin
         check_that(waited == 2 && first_hresp && hresp,
                    $sformatf("error response %0d cycles for addr %h size %0d", waited, addr, size));
      end else if (wr) begin
         check_that(!hresp, $sformatf("hresp on legal write to %h", addr));
      end else if (r_err) begin
         check_that(hresp && since_r == 2, $sformatf("read error at %h not reported", addr));
      end else begin
         check_that(!hresp && since_r == 1, $sformatf("read end misplaced at %h", addr));
         check_that(hrdata == shadow[word_index(addr)],
                    $sformatf("hrdata %h expected %h at %h", hrdata,
                              shadow[word_index(addr)], addr));
      end
      @(negedge bus_clk);
   endtask

   //******************************
   // AXI monitor
   //******************************
   always @(posedge bus_clk) begin
      axi_cmd_t wexp;
      axi_aw_t  aexp;
      if (arst_n) begin
         check_that(awvalid == wvalid, "awvalid and wvalid differ");
         check_that(bready && rready, "bready or rready not held high");
         if (awvalid && awready && wvalid && wready) begin
            axi_wr_count++;
            check_that(wr_exp_q.size() != 0, "AXI write with no legal AHB write behind it");
            if (wr_exp_q.size() != 0) begin
               wexp = wr_exp_q.pop_front();
               check_that(aw.addr == wexp.addr && aw.size == {1'b0, wexp.size} &&
                          w.strb == wexp.strb && w.data == wexp.wdata,
                          $sformatf("AXI write %h/%0d/%h/%h expected %h/%0d/%h/%h", aw.addr,
                                    aw.size, w.strb, w.data, wexp.addr, wexp.size, wexp.strb,
                                    wexp.wdata));
            end
         end
         if (arvalid && arready) begin
            axi_rd_count++;
            check_that(rd_exp_q.size() != 0, "AXI read with no legal AHB read behind it");
            if (rd_exp_q.size() != 0) begin
               aexp = rd_exp_q.pop_front();
               check_that(ar == aexp, $sformatf("AXI read %h/%0d expected %h/%0d", ar.addr,
                                                ar.size, aexp.addr, aexp.size));
            end
         end
      end
   end

   initial begin
      logic               wr;
      logic [2:0]         size;
      logic [`ADDR_W-1:0] addr;
      logic [`DATA_W-1:0] data;
      int                 pick;
      int                 waited;
      void'($urandom(32'h4974));
      arst_n   = 1'b0;
      haddr    = '0;
      hsize    = 3'd0;
      htrans   = `HTRANS_IDLE;
      hwrite   = 1'b0;
      hwdata   = '0;
      hsel     = 1'b0;
      hreadyin = 1'b1;                              // Single slave on the bus
      for (int i = 0; i < WORDS; i++) shadow[i] = fill_word(`LMEM_BASE + 32'(i * 8));
      repeat (10) begin
         @(posedge bus_clk);
         check_that(hreadyout && !hresp && !awvalid && !wvalid && !arvalid, "bad reset state");
      end
      @(negedge bus_clk);
      arst_n = 1'b1;
      @(posedge bus_clk);
      check_that(hreadyout && !hresp && !awvalid && !wvalid && !arvalid, "bad state after reset");
      @(negedge bus_clk);
      for (int t = 0; t < TRANSFERS; t++) begin
         wr   = $urandom % 2;
         size = wr ? ((($urandom % 5) == 0) ? 3'($urandom % 2) : 3'(2 + $urandom % 2))
                   : 3'($urandom % 4);
         pick = $urandom % 10;
         if (pick == 0) addr = `LMEM_BASE + `LMEM_SIZE + 32'($urandom % 'h100);  // Above window
         else if (pick == 1) addr = `LMEM_BASE - 32'd1 - 32'($urandom % 'h100);
         else if (pick < 6) addr = `LMEM_BASE + 32'($urandom % 'h100);          // Hot region
         else addr = `LMEM_BASE + 32'($urandom % `LMEM_SIZE);
         if (($urandom % 4) != 0) addr = addr & ~((32'd1 << size) - 32'd1);
         data = {$urandom, $urandom};
         run_transfer(wr, addr, size, data);
         idle_cycles($urandom % 3);
      end
      // Let the last command leave the slot
      waited = 0;
      while (awvalid || arvalid) begin
         @(posedge bus_clk);
         waited++;
         if (waited > TIMEOUT) give_up("command slot to drain");
      end
      repeat (2) @(posedge bus_clk);
      check_that(wr_exp_q.size() == 0 && rd_exp_q.size() == 0, "AHB transfers never sent on AXI");
      check_that(axi_wr_count == legal_wr && axi_rd_count == legal_rd,
                 $sformatf("AXI counts %0d/%0d for %0d/%0d legal transfers", axi_wr_count,
                           axi_rd_count, legal_wr, legal_rd));
      finish_run();
   end

endmodule

`default_nettype wire

// File: verilog/ahb_bridge_consts.svh
//******************************
// Bus widths, local memory window
// and AHB transfer type codes
//******************************
`ifndef AHB_BRIDGE_CONSTS_SVH
`define AHB_BRIDGE_CONSTS_SVH

// Bus widths
`define ADDR_W 32
`define DATA_W 64
`define STRB_W 8                          // One strobe per data byte

//******************************
// Local memory window
//******************************
`define LMEM_BASE 32'h2000_0000           // First byte of the window
`define LMEM_SIZE 32'h0001_0000           // 64 KiB

// HTRANS encodings
`define HTRANS_IDLE   2'b00
`define HTRANS_BUSY   2'b01
`define HTRANS_NONSEQ 2'b10

`endif

// File: verilog/ahb_req_check.sv
//******************************
// AHB address phase capture
// Window and alignment check, byte strobes
//******************************
`default_nettype none
`include "ahb_bridge_consts.svh"

module ahb_req_check import ahb_side_pkg::*; (
   input  logic               bus_clk,
   input  logic               arst_n,
   input  logic [`ADDR_W-1:0] haddr,
   input  logic [2:0]         hsize,
   input  logic [1:0]         htrans,
   input  logic               hwrite,
   input  logic               hsel,
   input  logic               hready,       // hreadyout & hreadyin
   output ahb_req_t           req,
   output logic               req_pending,  // Registered transfer in data phase
   output logic               hready_q,
   output logic               hresp_q,
   input  logic               hresp,
   output logic               req_fault
);

   logic [1:0]         htrans_in;
   logic [1:0]         htrans_q;
   logic               addr_accept;
   logic [`STRB_W-1:0] strb_in;
   logic               in_window;
   logic               size_fault;
   logic               align_fault;

   assign htrans_in   = hsel ? htrans : `HTRANS_IDLE;   // Ignore htrans when not selected
   assign addr_accept = hready && (htrans_in == `HTRANS_NONSEQ);

   // Byte lanes from size and low address bits
   always_comb begin
      case (hsize)
         3'd0:    strb_in = `STRB_W'(1) << haddr[2:0];
         3'd1:    strb_in = `STRB_W'(3) << haddr[2:0];
         3'd2:    strb_in = `STRB_W'(15) << haddr[2:0];
         3'd3:    strb_in = '1;                           // Full doubleword
         default: strb_in = '0;
      endcase
   end

   // Bus state seen by the FSM one cycle later
   always_ff @(posedge bus_clk or negedge arst_n) begin
      if (!arst_n) begin
         htrans_q <= `HTRANS_IDLE;
         hready_q <= 1'b0;
         hresp_q  <= 1'b0;
      end else begin
         htrans_q <= htrans_in;
         hready_q <= hready;
         hresp_q  <= hresp;
      end
   end

   // Address phase payload
   always_ff @(posedge bus_clk) begin
      if (addr_accept) begin
         req <= '{addr: haddr, size: hsize, write: hwrite, strb: strb_in};
      end
   end

   //******************************
   // Fault check on the registered request
   //******************************
   assign in_window  = (req.addr >= `LMEM_BASE) && (req.addr < (`LMEM_BASE + `LMEM_SIZE));
   assign size_fault = req.write && (req.size != 3'd2) && (req.size != 3'd3); // Word or dword writes

   always_comb begin
      case (req.size)
         3'd1:    align_fault = req.addr[0];
         3'd2:    align_fault = |req.addr[1:0];
         3'd3:    align_fault = |req.addr[2:0];
         default: align_fault = 1'b0;                     // Bytes never misalign
      endcase
   end

   assign req_fault   = !in_window || size_fault || align_fault;
   assign req_pending = (htrans_q != `HTRANS_IDLE) && (htrans_q != `HTRANS_BUSY);

endmodule

`default_nettype wire

// File: verilog/ahb_side_pkg.sv
//******************************
// AHB side types
// Registered request and bridge FSM state
//******************************
`default_nettype none
`include "ahb_bridge_consts.svh"

package ahb_side_pkg;

   // Address phase as captured at acceptance
   typedef struct packed {
      logic [`ADDR_W-1:0] addr;    // Byte address
      logic [2:0]         size;    // Raw hsize
      logic               write;   // High for a write
      logic [`STRB_W-1:0] strb;    // Byte lanes, built from size and addr[2:0]
   } ahb_req_t;

   // Bus FSM
   typedef enum logic [1:0] {
      IDLE = 2'b00,    // No transfer in its data phase
      WR   = 2'b01,    // Write data phase
      RD   = 2'b10,    // Read data phase, command not yet in slot
      PEND = 2'b11     // Read command sent, waiting on R
   } bridge_state_t;

endpackage

`default_nettype wire

// File: verilog/ahb_slave_fsm.sv
//******************************
// AHB bus FSM with hreadyout and hresp
// Command and read slot load controls
//******************************
`default_nettype none
`include "ahb_bridge_consts.svh"

module ahb_slave_fsm import ahb_side_pkg::*; (
   input  logic       bus_clk,
   input  logic       arst_n,
   input  logic [1:0] htrans,
   input  logic       hwrite,
   input  logic       hsel,
   input  logic       hreadyin,
   input  ahb_req_t   req,
   input  logic       req_pending,
   input  logic       hready_q,
   input  logic       hresp_q,
   input  logic       req_fault,
   input  logic       cmd_full,     // Slot busy and not leaving this cycle
   input  logic       cmd_write,    // Direction of the slot entry
   input  logic       rvalid,
   input  logic [1:0] rresp,
   input  logic       rd_err,       // Error from the read slot, one cycle
   output logic       hreadyout,
   output logic       hresp,
   output logic       hready,
   output logic       cmd_load,
   output logic       cmd_drop,
   output logic       rd_load,
   output logic       rd_err_in
);

   bridge_state_t state;
   bridge_state_t state_nxt;
   logic          state_en;
   logic          new_req;

   assign new_req = hready && hsel && (htrans == `HTRANS_NONSEQ);

   //******************************
   // Next state and slot loads
   //******************************
   always_comb begin
      state_nxt = IDLE;
      state_en  = 1'b0;
      cmd_load  = 1'b0;
      rd_load   = 1'b0;
      rd_err_in = 1'b0;
      case (state)
         IDLE: begin
            state_nxt = hwrite ? WR : RD;
            state_en  = new_req;                          // Move only on an accepted phase
         end
         WR: begin
            state_nxt = new_req ? (hwrite ? WR : RD) : IDLE;
            state_en  = !cmd_full || hresp;               // Hold while the slot is busy
            cmd_load  = !cmd_full && !hresp;              // Live hwdata goes in with the address
         end
         RD: begin
            state_nxt = hresp ? IDLE : PEND;
            state_en  = !cmd_full || hresp;
            cmd_load  = !cmd_full && !hresp;
         end
         PEND: begin
            state_nxt = IDLE;
            state_en  = rvalid && !cmd_write;             // Data back for our read
            rd_load   = state_en;
            rd_err_in = state_en && (rresp != 2'b00);
         end
      endcase
   end

   always_ff @(posedge bus_clk or negedge arst_n) begin
      if (!arst_n) begin
         state <= IDLE;
      end else if (state_en) begin
         state <= state_nxt;
      end
   end

   // Request fault, read error, or second error cycle
   assign hresp = (req_pending && (state != IDLE) && req_fault) ||
                  rd_err ||
                  (hresp_q && !hready_q);

   // First error cycle low, second high; reads stall until data is back
   assign hreadyout = hresp ? (hresp_q && !hready_q)
                            : ((!cmd_full || (state == IDLE)) && (state != RD) && (state != PEND));

   assign hready   = hreadyout && hreadyin;
   assign cmd_drop = hresp && !cmd_write;                 // Stale read never reaches AR

   //******************************
   // Checks
   //******************************
   err_two_cycle: assert property (@(posedge bus_clk) disable iff (!arst_n)
      (hready && hresp) |-> ($past(hresp) && !$past(hready)))
      else $error("hresp with hready not preceded by hresp without hready");

   no_load_when_full: assert property (@(posedge bus_clk) disable iff (!arst_n)
      cmd_load |-> !cmd_full)
      else $error("command slot loaded while full");

endmodule

`default_nettype wire

// File: verilog/ahb_to_axi_bridge.sv
//******************************
// AHB-Lite slave to AXI4 master bridge
// Single outstanding transfer
//******************************
`default_nettype none
`include "ahb_bridge_consts.svh"

module ahb_to_axi_bridge import ahb_side_pkg::*, axi_side_pkg::*; (
   input  logic               bus_clk,
   input  logic               arst_n,
   // AHB-Lite slave
   input  logic [`ADDR_W-1:0] haddr,
   input  logic [2:0]         hsize,
   input  logic [1:0]         htrans,
   input  logic               hwrite,
   input  logic [`DATA_W-1:0] hwdata,
   input  logic               hsel,
   input  logic               hreadyin,
   output logic [`DATA_W-1:0] hrdata,
   output logic               hreadyout,
   output logic               hresp,
   // AXI4 master
   output logic               awvalid,
   input  logic               awready,
   output axi_aw_t            aw,
   output logic               wvalid,
   input  logic               wready,
   output axi_w_t             w,
   input  logic               bvalid,     // Writes complete on AHB at the data phase
   output logic               bready,
   output logic               arvalid,
   input  logic               arready,
   output axi_aw_t            ar,
   input  logic               rvalid,
   output logic               rready,
   input  axi_r_t             r
);

   ahb_req_t  req;
   logic      req_pending;
   logic      hready_q;
   logic      hresp_q;
   logic      req_fault;
   logic      hready;
   logic      cmd_load;
   logic      cmd_drop;
   logic      cmd_valid;
   logic      cmd_accept;
   logic      cmd_full;
   logic      cmd_clear;
   axi_cmd_t  cmd_din;
   axi_cmd_t  cmd_q;
   logic      rd_load;
   logic      rd_err_in;
   logic      rd_valid;
   logic      rd_err;
   rd_entry_t rd_din;
   rd_entry_t rd_q;

   // Slot payloads
   assign cmd_din = '{write: req.write, addr: req.addr, size: req.size[1:0],
                      strb: req.strb, wdata: hwdata};
   assign rd_din    = '{data: r.data, err: rd_err_in};
   assign cmd_clear = cmd_accept || cmd_drop;
   assign rd_err    = rd_valid && rd_q.err;         // Read slot valid lasts one cycle
   assign hrdata    = rd_q.data;

   ahb_req_check req_check_inst (
      .bus_clk, .arst_n, .haddr, .hsize, .htrans, .hwrite, .hsel, .hready,
      .req, .req_pending, .hready_q, .hresp_q, .hresp, .req_fault
   );

   ahb_slave_fsm slave_fsm_inst (
      .bus_clk, .arst_n, .htrans, .hwrite, .hsel, .hreadyin, .req,
      .req_pending, .hready_q, .hresp_q, .req_fault,
      .cmd_full, .cmd_write(cmd_q.write), .rvalid, .rresp(r.resp), .rd_err,
      .hreadyout, .hresp, .hready, .cmd_load, .cmd_drop, .rd_load, .rd_err_in
   );

   hold_slot #(.payload_t(axi_cmd_t)) cmd_slot (
      .bus_clk, .arst_n, .load(cmd_load), .clear(cmd_clear),
      .din(cmd_din), .valid(cmd_valid), .dout(cmd_q)
   );

   hold_slot #(.payload_t(rd_entry_t)) rd_slot (
      .bus_clk, .arst_n, .load(rd_load), .clear(1'b1),
      .din(rd_din), .valid(rd_valid), .dout(rd_q)
   );

   axi_master_port master_port_inst (
      .cmd_valid, .cmd(cmd_q), .cmd_load,
      .awvalid, .awready, .wvalid, .wready, .arvalid, .arready,
      .aw, .w, .ar, .bready, .rready, .cmd_accept, .cmd_full
   );

endmodule

`default_nettype wire

// File: verilog/axi_master_port.sv
//******************************
// AXI4 master channels from the command slot
//******************************
`default_nettype none

module axi_master_port import axi_side_pkg::*; (
   input  logic     cmd_valid,
   input  axi_cmd_t cmd,
   input  logic     cmd_load,
   output logic     awvalid,
   input  logic     awready,
   output logic     wvalid,
   input  logic     wready,
   output logic     arvalid,
   input  logic     arready,
   output axi_aw_t  aw,
   output axi_w_t   w,
   output axi_aw_t  ar,
   output logic     bready,
   output logic     rready,
   output logic     cmd_accept,   // Slot entry leaves this cycle
   output logic     cmd_full
);

   logic wr_accept;
   logic rd_accept;

   // AW and W go out together from the same entry
   assign awvalid = cmd_valid && cmd.write;
   assign wvalid  = cmd_valid && cmd.write;
   assign arvalid = cmd_valid && !cmd.write;

   assign aw = '{addr: cmd.addr, size: {1'b0, cmd.size}};
   assign ar = '{addr: cmd.addr, size: {1'b0, cmd.size}};
   assign w  = '{data: cmd.wdata, strb: cmd.strb};

   assign bready = 1'b1;    // No write response tracking
   assign rready = 1'b1;    // Read slot always has room

   assign wr_accept  = awvalid && awready && wready;  // Both channels in one cycle
   assign rd_accept  = arvalid && arready;
   assign cmd_accept = wr_accept || rd_accept;
   assign cmd_full   = cmd_valid && !cmd_accept;

   // A new command never arrives while a read address is leaving
   no_load_on_ar: assert final (!(cmd_load && rd_accept))
      else $error("command loaded during AR handshake");

endmodule

`default_nettype wire

// File: verilog/axi_side_pkg.sv
//******************************
// AXI side types
// Command slot, channel payloads, read slot
//******************************
`default_nettype none
`include "ahb_bridge_consts.svh"

package axi_side_pkg;

   // Command slot entry, one transfer of either direction
   typedef struct packed {
      logic               write;   // High for AW+W, low for AR
      logic [`ADDR_W-1:0] addr;
      logic [1:0]         size;    // Bytes per beat as a power of two
      logic [`STRB_W-1:0] strb;
      logic [`DATA_W-1:0] wdata;   // Unused for reads
   } axi_cmd_t;

   // Address channel payload, same shape for AW and AR
   typedef struct packed {
      logic [`ADDR_W-1:0] addr;
      logic [2:0]         size;
   } axi_aw_t;

   // Write data channel
   typedef struct packed {
      logic [`DATA_W-1:0] data;
      logic [`STRB_W-1:0] strb;
   } axi_w_t;

   // Read data channel
   typedef struct packed {
      logic [`DATA_W-1:0] data;
      logic [1:0]         resp;    // Nonzero means slave error
   } axi_r_t;

   // Read slot entry seen on hrdata
   typedef struct packed {
      logic [`DATA_W-1:0] data;
      logic               err;     // Returned with error response
   } rd_entry_t;

endpackage

`default_nettype wire

// File: verilog/hold_slot.sv
//******************************
// One-entry holding register
//******************************
`default_nettype none

module hold_slot #(
   parameter type payload_t = logic
) (
   input  logic     bus_clk,
   input  logic     arst_n,
   input  logic     load,     // Wins over clear
   input  logic     clear,
   input  payload_t din,
   output logic     valid,
   output payload_t dout      // Keeps last entry after clear
);

   always_ff @(posedge bus_clk or negedge arst_n) begin
      if (!arst_n) begin
         valid <= 1'b0;
      end else if (load) begin
         valid <= 1'b1;
      end else if (clear) begin
         valid <= 1'b0;
      end
   end

   // Payload
   always_ff @(posedge bus_clk) begin
      if (load) begin
         dout <= din;
      end
   end

   // A held entry is only replaced on the cycle it leaves
   slot_no_overwrite: assert property (@(posedge bus_clk) disable iff (!arst_n)
      load |-> (!valid || clear))
      else $error("slot entry overwritten before release");

endmodule

`default_nettype wire
